//--- hdl/ocp_master_pkg.sv
// OCP master shared definitions
// Bus widths, OCP command and response codes, payload types

package ocp_master_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = DATA_W / 8;
  localparam int LEN_W  = 10;

  // Byte address step between consecutive burst words
  localparam int unsigned ADDR_INCR = BYTE_W;

  // Payload types
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BYTE_W-1:0] be_t;
  typedef logic [LEN_W-1:0]  len_t;

  // MCmd codes in use
  // Other OCP commands are not issued by this master
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    WR   = 3'd1,
    RD   = 3'd2
  } cmd_t;

  // SResp codes
  typedef enum logic [1:0] {
    NULL = 2'd0,
    DVA  = 2'd1,
    FAIL = 2'd2,
    ERR  = 2'd3
  } resp_t;

endpackage

//--- hdl/ocp_cmd_fsm.sv
// OCP command FSM
// Steps idle/write/read and flags burst start and word accept

`timescale 1ns/10ps

module ocp_cmd_fsm (
  input  logic                 Clk,
  input  logic                 reset,
  input  logic                 read_request,
  input  logic                 write_request,
  input  logic                 SCmdAccept,
  input  logic                 req_last,
  output ocp_master_pkg::cmd_t MCmd,
  output logic                 ocp_ready,
  output logic                 start,
  output logic                 advance
);

  import ocp_master_pkg::*;

  cmd_t state;
  cmd_t state_next;

  // Ready for a new request only in idle
  assign ocp_ready = (state == IDLE);

  // One-cycle pulse, state leaves idle on this edge
  assign start = ocp_ready & (read_request | write_request);

  // Word handed to the slave on this edge
  assign advance = (state != IDLE) & SCmdAccept;

  // Command is the state itself
  assign MCmd = state;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // Read has priority over write
        if (read_request) begin
          state_next = RD;
        end else if (write_request) begin
          state_next = WR;
        end
      end
      WR, RD: begin
        // Back to idle once the last word is taken
        if (advance && req_last) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- hdl/burst_addr_gen.sv
// Incrementing burst generator
// Holds the request fields and steps address, data and word count

`timescale 1ns/10ps

module burst_addr_gen (
  input  logic                  Clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  advance,
  input  ocp_master_pkg::addr_t address,
  input  ocp_master_pkg::len_t  burst_length,
  input  ocp_master_pkg::be_t   valid_bytes,
  input  ocp_master_pkg::data_t write_data,
  output ocp_master_pkg::addr_t MAddr,
  output ocp_master_pkg::data_t MData,
  output ocp_master_pkg::be_t   MByteEn,
  output ocp_master_pkg::len_t  MBurstLength,
  output logic                  MReqLast,
  output logic                  req_last
);

  import ocp_master_pkg::*;

  // Words accepted so far in this burst
  len_t burst_count;

  // Final word while count sits at length minus one
  assign MReqLast = (burst_count == (MBurstLength - len_t'(1)));

  // Same flag, fanned to the FSM
  assign req_last = MReqLast;

  // Count and length decide the last-word flag
  // Both cleared so the flag starts low
  always_ff @(posedge Clk) begin
    if (reset) begin
      burst_count  <= '0;
      MBurstLength <= '0;
    end else if (start) begin
      burst_count  <= '0;
      MBurstLength <= burst_length;
    end else if (advance) begin
      // Ends at the length, flag drops with it
      burst_count <= burst_count + len_t'(1);
    end
  end

  // Request payload
  always_ff @(posedge Clk) begin
    if (start) begin
      // Capture the bridge request
      MAddr   <= address;
      MByteEn <= valid_bytes;
      MData   <= write_data;
    end else if (advance) begin
      // Next word address, one word up
      MAddr <= MAddr + addr_t'(ADDR_INCR);

      // Source shows the next word once it sees this one accepted
      if (!MReqLast) begin
        MData <= write_data;
      end
    end
  end

endmodule

//--- hdl/resp_stream_slot.sv
// OCP response to stream slot
// One-entry holding register with back-pressure to the slave

`timescale 1ns/10ps

module resp_stream_slot (
  input  logic                  Clk,
  input  logic                  reset,
  input  ocp_master_pkg::resp_t SResp,
  input  ocp_master_pkg::data_t SData,
  input  logic                  SRespLast,
  input  logic                  s_axis_tready,
  output logic                  MRespAccept,
  output logic                  s_axis_tvalid,
  output ocp_master_pkg::data_t s_axis_tdata,
  output logic                  s_axis_tuser,
  output logic                  s_axis_tlast
);

  import ocp_master_pkg::*;

  logic resp_take;
  logic resp_load;

  // Room when empty or draining this cycle
  assign MRespAccept = ~s_axis_tvalid | s_axis_tready;

  // Response transfers on this edge
  assign resp_take = MRespAccept & (SResp != NULL);

  // Only DVA and FAIL reach the stream
  // ERR is taken and dropped
  assign resp_load = resp_take & ((SResp == DVA) | (SResp == FAIL));

  // Slot occupancy
  always_ff @(posedge Clk) begin
    if (reset) begin
      s_axis_tvalid <= 1'b0;
    end else if (resp_load) begin
      s_axis_tvalid <= 1'b1;
    end else if (s_axis_tready) begin
      s_axis_tvalid <= 1'b0;
    end
  end

  // Slot payload, held until the sink takes it
  always_ff @(posedge Clk) begin
    if (resp_load) begin
      s_axis_tdata <= SData;
      s_axis_tuser <= (SResp == FAIL);
      s_axis_tlast <= SRespLast;
    end
  end

endmodule

//--- hdl/ocp_master_top.sv
// OCP 2.2 single-thread burst master
// Bridge request in, OCP request group out, responses onto a stream port

`timescale 1ns/10ps

module ocp_master_top (
  input  logic                  Clk,
  input  logic                  reset,

  // Bridge side
  input  logic                  read_request,
  input  logic                  write_request,
  input  ocp_master_pkg::addr_t address,
  input  ocp_master_pkg::len_t  burst_length,
  input  ocp_master_pkg::be_t   valid_bytes,
  input  ocp_master_pkg::data_t write_data,
  output logic                  ocp_ready,

  // OCP request and response groups
  output ocp_master_pkg::cmd_t  MCmd,
  output ocp_master_pkg::addr_t MAddr,
  output ocp_master_pkg::data_t MData,
  output ocp_master_pkg::be_t   MByteEn,
  output ocp_master_pkg::len_t  MBurstLength,
  output logic                  MReqLast,
  output logic                  MRespAccept,
  input  logic                  SCmdAccept,
  input  ocp_master_pkg::resp_t SResp,
  input  ocp_master_pkg::data_t SData,
  input  logic                  SRespLast,

  // Response stream
  output logic                  s_axis_tvalid,
  output ocp_master_pkg::data_t s_axis_tdata,
  output logic                  s_axis_tuser,
  output logic                  s_axis_tlast,
  input  logic                  s_axis_tready
);

  // FSM to generator strobes
  logic start;
  logic advance;
  logic req_last;

  // Command state
  ocp_cmd_fsm u_cmd_fsm (
    .Clk           (Clk),
    .reset         (reset),
    .read_request  (read_request),
    .write_request (write_request),
    .SCmdAccept    (SCmdAccept),
    .req_last      (req_last),
    .MCmd          (MCmd),
    .ocp_ready     (ocp_ready),
    .start         (start),
    .advance       (advance)
  );

  // Request fields
  burst_addr_gen u_addr_gen (
    .Clk          (Clk),
    .reset        (reset),
    .start        (start),
    .advance      (advance),
    .address      (address),
    .burst_length (burst_length),
    .valid_bytes  (valid_bytes),
    .write_data   (write_data),
    .MAddr        (MAddr),
    .MData        (MData),
    .MByteEn      (MByteEn),
    .MBurstLength (MBurstLength),
    .MReqLast     (MReqLast),
    .req_last     (req_last)
  );

  // Response path, independent of the request side
  resp_stream_slot u_resp_slot (
    .Clk           (Clk),
    .reset         (reset),
    .SResp         (SResp),
    .SData         (SData),
    .SRespLast     (SRespLast),
    .s_axis_tready (s_axis_tready),
    .MRespAccept   (MRespAccept),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast)
  );

endmodule

//--- tests/ocp_master_checker.sv
// OCP master protocol checker
// Request hold, reset state and stream hold assertions

`timescale 1ns/10ps

module ocp_master_checker (
  input logic                  Clk,
  input logic                  reset,
  input ocp_master_pkg::cmd_t  MCmd,
  input ocp_master_pkg::addr_t MAddr,
  input ocp_master_pkg::data_t MData,
  input ocp_master_pkg::be_t   MByteEn,
  input ocp_master_pkg::len_t  MBurstLength,
  input logic                  MReqLast,
  input logic                  SCmdAccept,
  input logic                  s_axis_tvalid,
  input ocp_master_pkg::data_t s_axis_tdata,
  input logic                  s_axis_tuser,
  input logic                  s_axis_tlast,
  input logic                  s_axis_tready
);

  import ocp_master_pkg::*;

  // Stalled request keeps every field
  a_req_hold: assert property (@(posedge Clk) disable iff (reset)
    (MCmd != IDLE && !SCmdAccept) |=> (MCmd == $past(MCmd)) && $stable(MAddr) &&
    $stable(MData) && $stable(MByteEn) && $stable(MBurstLength) && $stable(MReqLast))
    else $error("request fields changed while stalled");

  a_reset_idle: assert property (@(posedge Clk) reset |=> MCmd == IDLE)
    else $error("MCmd not idle after reset");

  // Last flag only inside a burst
  a_last_idle: assert property (@(posedge Clk) disable iff (reset)
    (MCmd == IDLE) |-> !MReqLast)
    else $error("MReqLast high while idle");

  a_stream_hold: assert property (@(posedge Clk) disable iff (reset)
    (s_axis_tvalid && !s_axis_tready) |=> s_axis_tvalid && $stable(s_axis_tdata) &&
    $stable(s_axis_tuser) && $stable(s_axis_tlast))
    else $error("stream item changed while stalled");

endmodule

bind ocp_master_top ocp_master_checker u_checker (.*);

//--- tests/ocp_master_tb.sv
// OCP master testbench
// Table-driven bursts against a slave model and a stream sink

`timescale 1ns/10ps

module ocp_master_tb;

  import ocp_master_pkg::*;

  typedef struct {
    bit    is_read;
    addr_t addr;
    len_t  len;
    be_t   be;
    data_t base;
    bit    gap;
    bit    stall;
  } txn_t;

  typedef struct {
    resp_t resp;
    data_t data;
    logic  last;
  } rsp_t;

  typedef struct {
    data_t data;
    logic  user;
    logic  last;
  } item_t;

  localparam int NUM_TXN = 6;

  logic  Clk;
  logic  reset;
  logic  read_request;
  logic  write_request;
  addr_t address;
  len_t  burst_length;
  be_t   valid_bytes;
  data_t write_data;
  logic  ocp_ready;
  cmd_t  MCmd;
  addr_t MAddr;
  data_t MData;
  be_t   MByteEn;
  len_t  MBurstLength;
  logic  MReqLast;
  logic  MRespAccept;
  logic  SCmdAccept;
  resp_t SResp;
  data_t SData;
  logic  SRespLast;
  logic  s_axis_tvalid;
  data_t s_axis_tdata;
  logic  s_axis_tuser;
  logic  s_axis_tlast;
  logic  s_axis_tready;

  txn_t  txn_tab [NUM_TXN];
  rsp_t  rsp_q[$];
  item_t exp_q[$];
  bit    stall_on;
  bit    saw_backpressure;
  bit    table_loaded;

  ocp_master_top u_dut (.*);

  always #20 Clk = ~Clk;

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(input string what);
    $display("%s at %0t ns", what, $time);
    $display("sim failed");
    $fatal(1);
  endtask

  // Slave response side and stream sink, decisions just after the falling edge
  always @(negedge Clk) begin
    item_t item;
    if (rsp_q.size() > 0) begin
      SResp     = rsp_q[0].resp;
      SData     = rsp_q[0].data;
      SRespLast = rsp_q[0].last;
    end else begin
      SResp     = NULL;
      SData     = '0;
      SRespLast = 1'b0;
    end
    s_axis_tready = !stall_on;
    #1;
    // Response taken on the coming edge
    if (SResp != NULL && MRespAccept) begin
      if (SResp != ERR) begin
        exp_q.push_back('{SData, SResp == FAIL, SRespLast});
      end
      void'(rsp_q.pop_front());
    end
    if (!MRespAccept) saw_backpressure = 1'b1;
    // Stream item taken on the coming edge
    if (s_axis_tvalid === 1'b1 && s_axis_tready) begin
      if (exp_q.size() == 0) fail_plain("Stream item seen with no response pending");
      item = exp_q.pop_front();
      check("s_axis_tdata", s_axis_tdata, item.data);
      check("s_axis_tuser", s_axis_tuser, item.user);
      check("s_axis_tlast", s_axis_tlast, item.last);
    end
  end

  task automatic run_txn(input txn_t t);
    int unsigned count;
    addr_t       waddr;
    cmd_t        exp_cmd;
    exp_cmd          = t.is_read ? RD : WR;
    stall_on         = t.stall;
    saw_backpressure = 1'b0;
    read_request     = t.is_read;
    write_request    = !t.is_read;
    address          = t.addr;
    burst_length     = t.len;
    valid_bytes      = t.be;
    write_data       = t.base;
    @(negedge Clk);
    read_request  = 1'b0;
    write_request = 1'b0;
    check("ocp_ready", ocp_ready, 0);
    count = 0;
    while (count < t.len) begin
      check("MCmd", MCmd, exp_cmd);
      SCmdAccept = t.gap ? ($urandom % 3 != 0) : 1'b1;
      // Next word shown ahead of the accept edge
      write_data = t.base + data_t'(count + 1);
      if (SCmdAccept) begin
        waddr = t.addr + addr_t'(count * ADDR_INCR);
        check("MAddr", MAddr, waddr);
        check("MByteEn", MByteEn, t.be);
        check("MBurstLength", MBurstLength, t.len);
        check("MReqLast", MReqLast, count == t.len - 1);
        if (t.is_read) begin
          rsp_q.push_back('{waddr[4] ? FAIL : DVA, ~waddr, count == t.len - 1});
        end else begin
          check("MData", MData, t.base + data_t'(count));
        end
        count++;
      end
      @(negedge Clk);
    end
    SCmdAccept = 1'b0;
    check("ocp_ready", ocp_ready, 1);
    check("MCmd", MCmd, IDLE);
    check("MReqLast", MReqLast, 0);
    // Dropped by the slot, never seen on the stream
    if (t.is_read) rsp_q.push_back('{ERR, 32'hDEAD_BEEF, 1'b0});
    if (t.stall) begin
      repeat (4) @(negedge Clk);
      check("saw_backpressure", saw_backpressure, 1);
      stall_on = 1'b0;
    end
  endtask

  // Watchdog sized from the summed burst lengths
  initial begin
    int unsigned wd_cycles;
    wait (table_loaded);
    wd_cycles = 200;
    for (int i = 0; i < NUM_TXN; i++) wd_cycles += txn_tab[i].len * 20;
    #(wd_cycles * 40);
    $display("Timeout, watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h6b63_7ca5));
    Clk           = 1'b0;
    reset         = 1'b1;
    read_request  = 1'b0;
    write_request = 1'b0;
    address       = '0;
    burst_length  = '0;
    valid_bytes   = '0;
    write_data    = '0;
    SCmdAccept    = 1'b0;
    SResp         = NULL;
    SData         = '0;
    SRespLast     = 1'b0;
    s_axis_tready = 1'b1;
    stall_on      = 1'b0;
    // rd, addr, len, be, base, gap, stall
    txn_tab[0] = '{0, 32'h0000_1000, 10'd4, 4'hF, 32'hA000_0000, 0, 0};
    txn_tab[1] = '{1, 32'h0000_2000, 10'd8, 4'hF, 32'h0,         0, 0};
    txn_tab[2] = '{0, 32'h0000_3004, 10'd6, 4'h3, 32'hB000_0100, 1, 0};
    txn_tab[3] = '{1, 32'h0000_40F8, 10'd5, 4'hF, 32'h0,         1, 0};
    txn_tab[4] = '{1, 32'h0000_5000, 10'd6, 4'hF, 32'h0,         0, 1};
    txn_tab[5] = '{0, 32'h0000_6000, 10'd1, 4'h8, 32'hC000_0000, 1, 0};
    table_loaded = 1'b1;
    repeat (2) @(negedge Clk);
    reset = 1'b0;
    check("MCmd", MCmd, IDLE);
    check("ocp_ready", ocp_ready, 1);
    check("MRespAccept", MRespAccept, 1);
    check("s_axis_tvalid", s_axis_tvalid, 0);
    check("MReqLast", MReqLast, 0);
    @(negedge Clk);
    for (int i = 0; i < NUM_TXN; i++) run_txn(txn_tab[i]);
    // Drain the slave and the stream
    while (rsp_q.size() != 0 || exp_q.size() != 0 || s_axis_tvalid) @(negedge Clk);
    repeat (2) @(negedge Clk);
    $display("sim passed");
    $finish;
  end

endmodule

//--- list.f
hdl/ocp_master_pkg.sv
hdl/ocp_cmd_fsm.sv
hdl/burst_addr_gen.sv
hdl/resp_stream_slot.sv
hdl/ocp_master_top.sv
tests/ocp_master_checker.sv
tests/ocp_master_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the OCP master simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ocp_master_tb \
  -f list.f \
  -o sim_ocp_master

./obj_dir/sim_ocp_master | tee sim.log

if grep -q "^sim passed$" sim.log; then
  exit 0
else
  exit 1
fi
